// ==== rtl/warp_fetch_pkg.sv ====
`default_nettype none

package warp_fetch_pkg;

	localparam int num_warps = 8;
	localparam int pc_width = 32;
	localparam logic [pc_width-1:0] bundle_bytes = 8; // pc step of one fetch bundle.

	typedef logic [num_warps-1:0] warp_mask_t;
	typedef logic [$clog2(num_warps)-1:0] warp_id_t;

	// launch and redirect commands share this layout.
	typedef struct packed {
		logic valid;
		warp_id_t warp_id;
		logic [pc_width-1:0] pc;
	} pc_cmd_t;

	typedef struct packed {
		warp_mask_t warp_mask; // warp of the instruction decoded in this slot.
		logic exit_flag;
	} decode_slot_t;

	typedef struct packed {
		logic valid;
		warp_id_t warp_id;
		logic [pc_width-1:0] pc;
	} fetch_req_t;

	typedef struct packed {
		warp_mask_t grant_first;
		warp_mask_t grant_second;
	} grant_pair_t;

	// encodes a one-hot warp mask into its index, zero when the mask is empty.
	function automatic warp_id_t mask_to_id(input warp_mask_t mask);
		warp_id_t id;
		id = '0;
		for (int i = 0; i < num_warps; i++) begin
			if (mask[i]) begin
				id = warp_id_t'(i);
			end
		end
		return id;
	endfunction

endpackage

`default_nettype wire

// ==== rtl/fetch_control.sv ====
`timescale 1ns/1ns
`default_nettype none

module fetch_control (
	input  warp_fetch_pkg::pc_cmd_t launch,
	input  warp_fetch_pkg::pc_cmd_t redirect,
	input  warp_fetch_pkg::decode_slot_t decode_0,
	input  warp_fetch_pkg::decode_slot_t decode_1,
	output warp_fetch_pkg::warp_mask_t update_mask,
	output logic [warp_fetch_pkg::pc_width-1:0] update_pc,
	output warp_fetch_pkg::warp_mask_t exit_mask
);
	import warp_fetch_pkg::*;

	warp_mask_t launch_mask;
	warp_mask_t redirect_mask;
	warp_mask_t exit_0;
	warp_mask_t exit_1;

	always_comb begin
		launch_mask = warp_mask_t'(1) << launch.warp_id;
		redirect_mask = warp_mask_t'(1) << redirect.warp_id;
	end

	// a redirect overrides any launch in the same cycle.
	// when both name one warp the redirect target is the one written,
	// and when they name different warps the launch is simply lost.
	always_comb begin
		update_mask = '0;
		update_pc = launch.pc;
		if (redirect.valid) begin
			update_mask = redirect_mask;
			update_pc = redirect.pc;
		end else if (launch.valid) begin
			update_mask = launch_mask;
		end
	end

	always_comb begin
		exit_0 = decode_0.exit_flag ? decode_0.warp_mask : '0;
		exit_1 = decode_1.exit_flag ? decode_1.warp_mask : '0;
		exit_mask = exit_0 | exit_1; // both slots may retire exits together.
	end

endmodule

`default_nettype wire

// ==== rtl/pc_valid_tracker.sv ====
`timescale 1ns/1ns
`default_nettype none

module pc_valid_tracker (
	input  logic clk,
	input  logic rst_n,
	input  warp_fetch_pkg::warp_mask_t update_mask,
	input  warp_fetch_pkg::warp_mask_t exit_mask,
	output warp_fetch_pkg::warp_mask_t pc_valid_next,
	output warp_fetch_pkg::warp_mask_t pc_valid
);
	import warp_fetch_pkg::*;

	// an exit wins over a launch or redirect of the same warp.
	always_comb begin
		for (int i = 0; i < num_warps; i++) begin
			if (exit_mask[i]) begin
				pc_valid_next[i] = 1'b0;
			end else if (update_mask[i]) begin
				pc_valid_next[i] = 1'b1;
			end else begin
				pc_valid_next[i] = pc_valid[i];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc_valid <= '0;
		end else begin
			pc_valid <= pc_valid_next;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/dual_grant_arbiter.sv ====
`timescale 1ns/1ns
`default_nettype none

module dual_grant_arbiter (
	input  logic clk,
	input  logic rst_n,
	input  warp_fetch_pkg::warp_mask_t ibuf_req,
	input  warp_fetch_pkg::warp_mask_t simt_stall,
	input  warp_fetch_pkg::warp_mask_t pc_valid_next,
	output warp_fetch_pkg::grant_pair_t grants
);
	import warp_fetch_pkg::*;

	warp_id_t ptr_q; // last granted warp.
	warp_id_t ptr_next;
	warp_mask_t eligible;
	warp_mask_t rotated;
	warp_mask_t first_rot;
	warp_mask_t second_rot;

	// moves the warp after ptr down to bit 0, so bit 0 has top priority.
	function automatic warp_mask_t rotate_to_ptr(input warp_mask_t vec, input warp_id_t ptr);
		warp_mask_t res;
		warp_id_t src;
		for (int i = 0; i < num_warps; i++) begin
			src = ptr + warp_id_t'(i) + warp_id_t'(1);
			res[i] = vec[src];
		end
		return res;
	endfunction

	function automatic warp_mask_t rotate_from_ptr(input warp_mask_t vec, input warp_id_t ptr);
		warp_mask_t res;
		warp_id_t dst;
		for (int i = 0; i < num_warps; i++) begin
			dst = ptr + warp_id_t'(i) + warp_id_t'(1);
			res[dst] = vec[i];
		end
		return res;
	endfunction

	// fixed priority, lowest bit first.
	function automatic warp_mask_t first_set(input warp_mask_t vec);
		warp_mask_t res;
		logic found;
		res = '0;
		found = 1'b0;
		for (int i = 0; i < num_warps; i++) begin
			if (vec[i] && !found) begin
				res[i] = 1'b1;
				found = 1'b1;
			end
		end
		return res;
	endfunction

	always_comb begin
		eligible = ibuf_req & ~simt_stall & pc_valid_next;
		rotated = rotate_to_ptr(eligible, ptr_q);
		first_rot = first_set(rotated);
		second_rot = first_set(rotated & ~first_rot); // second pass skips the first winner.
		grants.grant_first = rotate_from_ptr(first_rot, ptr_q);
		grants.grant_second = rotate_from_ptr(second_rot, ptr_q);
	end

	// the next search starts just past the last warp that won.
	always_comb begin
		ptr_next = ptr_q;
		if (|grants.grant_second) begin
			ptr_next = mask_to_id(grants.grant_second);
		end else if (|grants.grant_first) begin
			ptr_next = mask_to_id(grants.grant_first);
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ptr_q <= warp_id_t'(num_warps - 1); // warp 0 goes first out of reset.
		end else begin
			ptr_q <= ptr_next;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/warp_pc_table.sv ====
`timescale 1ns/1ns
`default_nettype none

module warp_pc_table (
	input  logic clk,
	input  logic rst_n,
	input  warp_fetch_pkg::warp_mask_t update_mask,
	input  logic [warp_fetch_pkg::pc_width-1:0] update_pc,
	input  warp_fetch_pkg::grant_pair_t grants,
	output logic [warp_fetch_pkg::num_warps-1:0][warp_fetch_pkg::pc_width-1:0] pcs
);
	import warp_fetch_pkg::*;

	warp_mask_t granted;

	assign granted = grants.grant_first | grants.grant_second;

	// a launch or redirect replaces the pc even if the warp was granted.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pcs <= '0;
		end else begin
			for (int i = 0; i < num_warps; i++) begin
				if (update_mask[i]) begin
					pcs[i] <= update_pc;
				end else if (granted[i]) begin
					pcs[i] <= pcs[i] + bundle_bytes;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== rtl/fetch_request_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module fetch_request_gen (
	input  logic clk,
	input  logic rst_n,
	input  warp_fetch_pkg::grant_pair_t grants,
	input  logic [warp_fetch_pkg::num_warps-1:0][warp_fetch_pkg::pc_width-1:0] pcs,
	input  warp_fetch_pkg::warp_mask_t update_mask,
	input  logic [warp_fetch_pkg::pc_width-1:0] update_pc,
	output warp_fetch_pkg::fetch_req_t fetch_0,
	output warp_fetch_pkg::fetch_req_t fetch_1
);
	import warp_fetch_pkg::*;

	fetch_req_t req_0;
	fetch_req_t req_1;

	// builds one request from a one-hot grant.
	// a pc written this cycle is forwarded, so a warp launched or redirected
	// in the grant cycle fetches from its new target.
	function automatic fetch_req_t build_req(
		input warp_mask_t grant,
		input logic [num_warps-1:0][pc_width-1:0] pc_table,
		input warp_mask_t upd_mask,
		input logic [pc_width-1:0] upd_pc
	);
		fetch_req_t req;
		warp_id_t id;
		id = mask_to_id(grant);
		req.valid = |grant;
		req.warp_id = id;
		req.pc = upd_mask[id] ? upd_pc : pc_table[id];
		return req;
	endfunction

	always_comb begin
		req_0 = build_req(grants.grant_first, pcs, update_mask, update_pc);
		req_1 = build_req(grants.grant_second, pcs, update_mask, update_pc);
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			fetch_0 <= '0;
			fetch_1 <= '0;
		end else begin
			fetch_0 <= req_0;
			fetch_1 <= req_1;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/warp_fetch_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module warp_fetch_top (
	input  logic clk,
	input  logic rst_n,
	input  warp_fetch_pkg::warp_mask_t ibuf_req,
	input  warp_fetch_pkg::warp_mask_t simt_stall,
	input  warp_fetch_pkg::pc_cmd_t launch,
	input  warp_fetch_pkg::pc_cmd_t redirect,
	input  warp_fetch_pkg::decode_slot_t decode_0,
	input  warp_fetch_pkg::decode_slot_t decode_1,
	output warp_fetch_pkg::fetch_req_t fetch_0,
	output warp_fetch_pkg::fetch_req_t fetch_1,
	output warp_fetch_pkg::warp_mask_t pc_valid
);
	import warp_fetch_pkg::*;

	warp_mask_t update_mask;
	warp_mask_t exit_mask;
	warp_mask_t pc_valid_next;
	logic [pc_width-1:0] update_pc;
	grant_pair_t grants;
	logic [num_warps-1:0][pc_width-1:0] pcs;

	fetch_control u_fetch_control (
		.launch      (launch),
		.redirect    (redirect),
		.decode_0    (decode_0),
		.decode_1    (decode_1),
		.update_mask (update_mask),
		.update_pc   (update_pc),
		.exit_mask   (exit_mask)
	);

	pc_valid_tracker u_pc_valid_tracker (
		.clk           (clk),
		.rst_n         (rst_n),
		.update_mask   (update_mask),
		.exit_mask     (exit_mask),
		.pc_valid_next (pc_valid_next),
		.pc_valid      (pc_valid)
	);

	// the arbiter sees this cycle's launches and exits through pc_valid_next.
	dual_grant_arbiter u_dual_grant_arbiter (
		.clk           (clk),
		.rst_n         (rst_n),
		.ibuf_req      (ibuf_req),
		.simt_stall    (simt_stall),
		.pc_valid_next (pc_valid_next),
		.grants        (grants)
	);

	warp_pc_table u_warp_pc_table (
		.clk         (clk),
		.rst_n       (rst_n),
		.update_mask (update_mask),
		.update_pc   (update_pc),
		.grants      (grants),
		.pcs         (pcs)
	);

	fetch_request_gen u_fetch_request_gen (
		.clk         (clk),
		.rst_n       (rst_n),
		.grants      (grants),
		.pcs         (pcs),
		.update_mask (update_mask),
		.update_pc   (update_pc),
		.fetch_0     (fetch_0),
		.fetch_1     (fetch_1)
	);

endmodule

`default_nettype wire

// ==== test/warp_fetch_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module warp_fetch_tb;
	import warp_fetch_pkg::*;

	localparam int reset_cycles = 8;
	localparam int random_cycles = 300;

	typedef struct packed {
		logic [3:0] test;
		warp_mask_t req;
		warp_mask_t stall;
		pc_cmd_t launch_cmd;
		pc_cmd_t redirect_cmd;
		decode_slot_t dec_0;
		decode_slot_t dec_1;
		fetch_req_t exp_0; // requests expected one cycle after this row is applied.
		fetch_req_t exp_1;
	} row_t;

	logic clk;
	logic rst_n;
	warp_mask_t ibuf_req;
	warp_mask_t simt_stall;
	pc_cmd_t launch;
	pc_cmd_t redirect;
	decode_slot_t decode_0;
	decode_slot_t decode_1;
	fetch_req_t fetch_0;
	fetch_req_t fetch_1;
	warp_mask_t pc_valid;

	row_t table_rows[$];
	string test_names [7];
	int test_errors [7];
	int total_checks;
	int tests_passed;
	int tests_failed;
	int cycle_count = 0;
	logic [15:0] lfsr_state;

	// reference state of the scheduler.
	int m_ptr;
	warp_mask_t m_valid;
	logic [pc_width-1:0] m_pcs [num_warps];

	warp_fetch_top DUT (
		.clk        (clk),
		.rst_n      (rst_n),
		.ibuf_req   (ibuf_req),
		.simt_stall (simt_stall),
		.launch     (launch),
		.redirect   (redirect),
		.decode_0   (decode_0),
		.decode_1   (decode_1),
		.fetch_0    (fetch_0),
		.fetch_1    (fetch_1),
		.pc_valid   (pc_valid)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= reset_cycles + table_rows.size() + random_cycles + 20) begin
			$display("timeout: the run went on for %0d cycles without finishing", cycle_count);
			$display("Verification failed");
			$finish;
		end
	end

	function automatic pc_cmd_t make_cmd(input logic valid, input int id, input int pc);
		pc_cmd_t cmd;
		cmd.valid = valid;
		cmd.warp_id = warp_id_t'(id);
		cmd.pc = pc_width'(pc);
		return cmd;
	endfunction

	function automatic fetch_req_t make_req(input logic valid, input int id, input int pc);
		fetch_req_t req;
		req.valid = valid;
		req.warp_id = warp_id_t'(id);
		req.pc = pc_width'(pc);
		return req;
	endfunction

	function automatic decode_slot_t make_slot(input warp_mask_t mask, input logic exit_flag);
		decode_slot_t slot;
		slot.warp_mask = mask;
		slot.exit_flag = exit_flag;
		return slot;
	endfunction

	// id and pc of an invalid request carry no meaning.
	function automatic logic req_matches(input fetch_req_t actual, input fetch_req_t expected);
		if (actual.valid !== expected.valid) begin
			return 1'b0;
		end
		if (!expected.valid) begin
			return 1'b1;
		end
		return actual.warp_id === expected.warp_id && actual.pc === expected.pc;
	endfunction

	// x^16 + x^14 + x^13 + x^11 + 1.
	function automatic logic next_lfsr_bit();
		logic fb;
		fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
		lfsr_state = {lfsr_state[14:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], next_lfsr_bit()};
		end
		return v;
	endfunction

	task automatic add_row(input int test, input warp_mask_t req, input warp_mask_t stall,
			input pc_cmd_t l_cmd, input pc_cmd_t r_cmd, input decode_slot_t d0,
			input decode_slot_t d1, input fetch_req_t e0, input fetch_req_t e1);
		row_t r;
		r = {4'(test), req, stall, l_cmd, r_cmd, d0, d1, e0, e1};
		table_rows.push_back(r);
	endtask

	task automatic build_table();
		pc_cmd_t idle;
		decode_slot_t none;
		fetch_req_t nf;
		idle = make_cmd(0, 0, 0);
		none = make_slot('0, 1'b0);
		nf = make_req(0, 0, 0);
		add_row(1, 8'h00, 8'h00, make_cmd(1, 0, 'h100), idle, none, none, nf, nf);
		add_row(1, 8'h00, 8'h00, idle, idle, none, none, nf, nf);
		for (int w = 1; w < num_warps; w++) begin
			add_row(2, 8'h00, 8'h00, make_cmd(1, w, (w + 1) * 'h100), idle, none, none, nf, nf);
		end
		add_row(2, 8'hff, 8'h00, idle, idle, none, none,
			make_req(1, 0, 'h100), make_req(1, 1, 'h200));
		add_row(2, 8'hff, 8'h00, idle, idle, none, none,
			make_req(1, 2, 'h300), make_req(1, 3, 'h400));
		add_row(2, 8'hff, 8'h00, idle, idle, none, none,
			make_req(1, 4, 'h500), make_req(1, 5, 'h600));
		add_row(2, 8'hff, 8'h00, idle, idle, none, none,
			make_req(1, 6, 'h700), make_req(1, 7, 'h800));
		add_row(2, 8'hff, 8'h00, idle, idle, none, none,
			make_req(1, 0, 'h108), make_req(1, 1, 'h208));
		add_row(3, 8'hff, 8'hff, idle, idle, none, none, nf, nf);
		add_row(3, 8'h0f, 8'h05, idle, idle, none, none,
			make_req(1, 3, 'h408), make_req(1, 1, 'h210)); // search wraps past warp 7.
		add_row(3, 8'h80, 8'h00, idle, idle, make_slot(8'h80, 1'b1), none, nf, nf);
		add_row(3, 8'h80, 8'h00, idle, idle, none, none, nf, nf);
		add_row(3, 8'h44, 8'h04, idle, idle, none, none, make_req(1, 6, 'h708), nf);
		add_row(4, 8'h08, 8'h00, idle, idle, none, none, make_req(1, 3, 'h410), nf);
		add_row(4, 8'h08, 8'h00, idle, idle, none, none, make_req(1, 3, 'h418), nf);
		add_row(4, 8'h08, 8'h00, idle, make_cmd(1, 3, 'h4000), none, none,
			make_req(1, 3, 'h4000), nf);
		add_row(4, 8'h08, 8'h00, idle, idle, none, none, make_req(1, 3, 'h4000), nf);
		add_row(4, 8'h08, 8'h00, idle, idle, none, none, make_req(1, 3, 'h4008), nf);
		// the launch of warp 7 loses against the redirect and must leave warp 7 invalid.
		add_row(4, 8'h03, 8'h00, make_cmd(1, 7, 'h9000), make_cmd(1, 1, 'h5000), none, none,
			make_req(1, 0, 'h110), make_req(1, 1, 'h5000));
		add_row(5, 8'h30, 8'h00, idle, idle, none, make_slot(8'h20, 1'b1),
			make_req(1, 4, 'h508), nf);
		add_row(5, 8'h30, 8'h00, idle, idle, none, none, make_req(1, 4, 'h510), nf);
		add_row(5, 8'h20, 8'h00, make_cmd(1, 5, 'h6000), idle, make_slot(8'h20, 1'b1), none,
			nf, nf);
		add_row(5, 8'h20, 8'h00, idle, idle, none, none, nf, nf);
		add_row(5, 8'h20, 8'h00, make_cmd(1, 5, 'h7000), idle, none, none,
			make_req(1, 5, 'h7000), nf);
		add_row(5, 8'h03, 8'h00, idle, idle, make_slot(8'h01, 1'b1), make_slot(8'h02, 1'b1),
			nf, nf);
		add_row(5, 8'h07, 8'h00, idle, idle, make_slot(8'h04, 1'b0), none,
			make_req(1, 2, 'h308), nf);
	endtask

	task automatic reset_model();
		m_ptr = num_warps - 1;
		m_valid = '0;
		for (int i = 0; i < num_warps; i++) begin
			m_pcs[i] = '0;
		end
	endtask

	// one clock of the scheduler rules, returning the requests seen one cycle later.
	task automatic predict_cycle(input warp_mask_t req, input warp_mask_t stall,
			input pc_cmd_t l_cmd, input pc_cmd_t r_cmd, input decode_slot_t d0,
			input decode_slot_t d1, output fetch_req_t p0, output fetch_req_t p1);
		warp_mask_t upd;
		warp_mask_t ext;
		warp_mask_t elig;
		warp_mask_t granted;
		logic [pc_width-1:0] new_pc;
		int w;
		int hits;
		int picked [2];
		upd = '0;
		new_pc = '0;
		if (r_cmd.valid) begin
			upd[r_cmd.warp_id] = 1'b1;
			new_pc = r_cmd.pc;
		end else if (l_cmd.valid) begin
			upd[l_cmd.warp_id] = 1'b1;
			new_pc = l_cmd.pc;
		end
		ext = (d0.exit_flag ? d0.warp_mask : '0) | (d1.exit_flag ? d1.warp_mask : '0);
		m_valid = (m_valid | upd) & ~ext;
		elig = req & ~stall & m_valid;
		hits = 0;
		granted = '0;
		for (int k = 1; k <= num_warps; k++) begin
			w = (m_ptr + k) % num_warps;
			if (elig[w] && hits < 2) begin
				picked[hits] = w;
				granted[w] = 1'b1;
				hits++;
			end
		end
		p0 = make_req(0, 0, 0);
		p1 = make_req(0, 0, 0);
		if (hits > 0) begin
			p0 = make_req(1, picked[0], upd[picked[0]] ? new_pc : m_pcs[picked[0]]);
			m_ptr = picked[hits - 1];
		end
		if (hits > 1) begin
			p1 = make_req(1, picked[1], upd[picked[1]] ? new_pc : m_pcs[picked[1]]);
		end
		for (int i = 0; i < num_warps; i++) begin
			if (upd[i]) begin
				m_pcs[i] = new_pc;
			end else if (granted[i]) begin
				m_pcs[i] = m_pcs[i] + pc_width'(8);
			end
		end
	endtask

	task automatic check_outputs(input fetch_req_t e0, input fetch_req_t e1,
			input warp_mask_t ev, input int test);
		total_checks++;
		if (!req_matches(fetch_0, e0)) begin
			$display("** Error at %0t ns: fetch_0 = %h, expected %h", $time, fetch_0, e0);
			test_errors[test]++;
		end
		if (!req_matches(fetch_1, e1)) begin
			$display("** Error at %0t ns: fetch_1 = %h, expected %h", $time, fetch_1, e1);
			test_errors[test]++;
		end
		if (pc_valid !== ev) begin
			$display("** Error at %0t ns: pc_valid = %h, expected %h", $time, pc_valid, ev);
			test_errors[test]++;
		end
	endtask

	task automatic apply_row(input int idx);
		row_t r;
		fetch_req_t p0;
		fetch_req_t p1;
		r = table_rows[idx];
		ibuf_req = r.req;
		simt_stall = r.stall;
		launch = r.launch_cmd;
		redirect = r.redirect_cmd;
		decode_0 = r.dec_0;
		decode_1 = r.dec_1;
		predict_cycle(r.req, r.stall, r.launch_cmd, r.redirect_cmd, r.dec_0, r.dec_1, p0, p1);
		if (!req_matches(p0, r.exp_0) || !req_matches(p1, r.exp_1)) begin
			$display("table row %0d: the reference model predicts other requests than the table",
				idx);
			test_errors[r.test]++;
		end
		@(negedge clk);
		check_outputs(r.exp_0, r.exp_1, m_valid, r.test);
	endtask

	// launches come one cycle in four, redirects and each exit slot one in eight.
	task automatic run_random();
		fetch_req_t p0;
		fetch_req_t p1;
		for (int c = 0; c < random_cycles; c++) begin
			ibuf_req = warp_mask_t'(random_bits(8));
			simt_stall = warp_mask_t'(random_bits(8) & random_bits(8));
			launch = make_cmd(random_bits(2) == 32'd3, random_bits(3), random_bits(13) << 3);
			redirect = make_cmd(random_bits(3) == 32'd7, random_bits(3), random_bits(13) << 3);
			decode_0 = make_slot(warp_mask_t'(1) << random_bits(3), random_bits(3) == 32'd7);
			decode_1 = make_slot(warp_mask_t'(1) << random_bits(3), random_bits(3) == 32'd7);
			predict_cycle(ibuf_req, simt_stall, launch, redirect, decode_0, decode_1, p0, p1);
			@(negedge clk);
			check_outputs(p0, p1, m_valid, 6);
		end
	endtask

	task automatic report_test(input int n);
		$display("test %0d, %s: %s with %0d errors", n, test_names[n],
			test_errors[n] == 0 ? "ok" : "FAILED", test_errors[n]);
		if (test_errors[n] == 0) begin
			tests_passed++;
		end else begin
			tests_failed++;
		end
	endtask

	initial begin
		rst_n = 1'b0;
		ibuf_req = '0;
		simt_stall = '0;
		launch = '0;
		redirect = '0;
		decode_0 = '0;
		decode_1 = '0;
		lfsr_state = 16'd26363;
		total_checks = 0;
		tests_passed = 0;
		tests_failed = 0;
		test_names[1] = "reset and launch";
		test_names[2] = "rotating pairs";
		test_names[3] = "ineligible warps";
		test_names[4] = "pc advance and redirect";
		test_names[5] = "exits";
		test_names[6] = "random stimulus";
		for (int i = 0; i < 7; i++) begin
			test_errors[i] = 0;
		end
		build_table();
		reset_model();
		repeat (reset_cycles) @(negedge clk);
		rst_n = 1'b1;
		check_outputs(make_req(0, 0, 0), make_req(0, 0, 0), '0, 1);
		for (int i = 0; i < table_rows.size(); i++) begin
			apply_row(i);
			if (i == table_rows.size() - 1 || table_rows[i + 1].test != table_rows[i].test) begin
				report_test(table_rows[i].test);
			end
		end
		run_random();
		report_test(6);
		$display("%0d tests passed, %0d tests failed, %0d checks", tests_passed, tests_failed,
			total_checks);
		if (tests_failed == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
rtl/warp_fetch_pkg.sv
rtl/fetch_control.sv
rtl/pc_valid_tracker.sv
rtl/dual_grant_arbiter.sv
rtl/warp_pc_table.sv
rtl/fetch_request_gen.sv
rtl/warp_fetch_top.sv
test/warp_fetch_tb.sv
